/* Makefile */
# Verilator build and run of the sound blaster dsp testbench

VERILATOR ?= verilator
TOP       ?= sb_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/sb_tb.sv */
// sound blaster dsp testbench
// host port tasks, dma responder, sample collector and reference models
`timescale 1ns/1ps
`include "sb_consts.svh"

module sb_tb;
	import sb_pkg::*;

	localparam int CLK_NS = 4;
	localparam int TC = 254;          // two rate counts per sample
	localparam int EDGE_CYC = 34;     // cycles per prescaler top bit change
	localparam int TICK_CYC = EDGE_CYC * (256 - TC);
	localparam int PCM_N = 6;
	localparam int AUTO_B = 4;
	localparam int ADPCM_BYTES = 4;   // reference byte included
	localparam int SIL_L = 8;
	localparam int SETTLE_TICKS = 4;
	localparam int PAUSE_TICKS = 8;
	localparam int TEST_TICKS = PCM_N + 3 * AUTO_B + 2 * ADPCM_BYTES + SIL_L
		+ 4 * SETTLE_TICKS + PAUSE_TICKS;
	// first tick after reset needs a full 256 count
	localparam int WATCHDOG_CYC = 2 * (256 * EDGE_CYC + TEST_TICKS * TICK_CYC);

	logic               CLK;
	logic               dsp_reset;
	logic               i_io_wr;
	logic               i_io_rd;
	logic [15:0]        i_io_addr;
	logic [7:0]         i_io_wdata;
	logic [7:0]         o_io_rdata;
	logic               o_dma_req;
	logic               i_dma_valid;
	logic [7:0]         i_dma_data;
	logic               o_irq;
	logic signed [15:0] o_audio;
	logic               o_audio_stb;

	logic [31:0]        lfsr;
	logic [7:0]         dma_q[$];
	logic signed [15:0] exp_q[$];
	int                 host_errs;
	int                 audio_errs;
	int                 dma_errs;
	int                 dma_reqs;
	int                 strobes;

	sb_dsp_top UUT (.*);

	initial
	begin
		CLK = 1'b0;
		forever #(CLK_NS / 2) CLK = ~CLK;
	end

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		for (int i = 0; i < 8; i++)
			b = {b[6:0], lfsr_step()};
		return b;
	endfunction

	// offset binary byte to signed 16-bit
	function automatic logic signed [15:0] pcm_ref(input logic [7:0] b);
		int v;
		v = (int'(b) - 128) * 128;
		return 16'(v);
	endfunction

	function automatic int adpcm_next(input int prev, input int shift, input logic [3:0] code);
		int step;
		int v;
		step = int'(code[2:0]) << shift;
		if (shift != 0)
			step = step + ((1 << shift) >> 1); // half a shift unit
		v = code[3] ? prev - step : prev + step;
		if (v < 0)
			v = 0;
		else if (v > 255)
			v = 255;
		return v;
	endfunction

	function automatic int adpcm_shift(input int shift, input logic [3:0] code);
		if (code[2:0] >= 3'd5 && shift < 3)
			return shift + 1;
		if (code[2:0] == 3'd0 && shift > 0)
			return shift - 1;
		return shift;
	endfunction

	task automatic check_reply(input string what, input reply_t got, input reply_t exp);
		if (got !== exp)
		begin
			host_errs++;
			$display("[FAIL] %s: got %h expected %h", what, got, exp);
		end
	endtask

	task automatic check_audio(input logic signed [15:0] got, input logic signed [15:0] exp);
		if (got !== exp)
		begin
			audio_errs++;
			$display("[FAIL] o_audio: got %h expected %h", got, exp);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp)
		begin
			host_errs++;
			$display("[FAIL] %s: got %h expected %h", what, got, exp);
		end
	endtask

	task automatic io_write(input logic [3:0] ofs, input logic [7:0] data);
		@(negedge CLK);
		i_io_addr = `SB_BASE | {12'd0, ofs};
		i_io_wdata = data;
		i_io_wr = 1'b1;
		@(negedge CLK);
		i_io_wr = 1'b0;
	endtask

	task automatic io_read(input logic [3:0] ofs, output logic [7:0] data);
		@(negedge CLK);
		i_io_addr = `SB_BASE | {12'd0, ofs};
		i_io_rd = 1'b1;
		@(negedge CLK);
		i_io_rd = 1'b0;
		data = o_io_rdata; // registered on the edge in between
	endtask

	task automatic dsp_write(input logic [7:0] data);
		logic [7:0] st;
		st = 8'hFF;
		while (st[7])
			io_read(`SB_OFS_WRITE, st);
		io_write(`SB_OFS_WRITE, data);
		repeat (3) @(negedge CLK); // byte reaches the FSM
	endtask

	task automatic dsp_read(output reply_t r);
		logic [7:0] st;
		logic [7:0] d;
		st = 8'h00;
		while (!st[7])
			io_read(`SB_OFS_STATUS, st);
		io_read(`SB_OFS_READ, d);
		r = {st[7], d};
	endtask

	task automatic wait_irq();
		while (!o_irq)
			@(negedge CLK);
	endtask

	task automatic wait_samples();
		while (exp_q.size() != 0)
			@(negedge CLK);
	endtask

	task automatic settle();
		repeat (SETTLE_TICKS * TICK_CYC) @(negedge CLK);
	endtask

	task automatic queue_pcm(input int n, input logic spk_on);
		logic [7:0] b;
		for (int i = 0; i < n; i++)
		begin
			b = rand_byte();
			dma_q.push_back(b);
			exp_q.push_back(spk_on ? pcm_ref(b) : 16'sd0);
		end
	endtask

	// dma responder
	initial
	begin
		i_dma_valid = 1'b0;
		i_dma_data = 8'h00;
		dma_errs = 0;
		dma_reqs = 0;
		forever
		begin
			@(negedge CLK);
			if (o_dma_req)
			begin
				dma_reqs++;
				repeat (3) @(negedge CLK);
				if (dma_q.size() == 0)
				begin
					dma_errs++;
					$display("DMA request arrived with no byte left to send");
				end
				else
				begin
					i_dma_data = dma_q.pop_front();
					i_dma_valid = 1'b1;
					@(negedge CLK);
					i_dma_valid = 1'b0;
				end
			end
		end
	end

	// sample collector
	initial
	begin
		audio_errs = 0;
		strobes = 0;
		forever
		begin
			@(negedge CLK);
			if (o_audio_stb)
			begin
				strobes++;
				if (exp_q.size() == 0)
				begin
					audio_errs++;
					$display("audio strobe came with no sample expected");
				end
				else
					check_audio(o_audio, exp_q.pop_front());
			end
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYC) @(posedge CLK);
		$display("timeout after %0d cycles, the run did not finish", WATCHDOG_CYC);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		reply_t     r;
		logic [7:0] st;
		logic [7:0] x;
		logic [7:0] b;
		logic [3:0] code;
		int         level;
		int         shift;
		int         base;
		int         snap;

		lfsr = 32'hb64f5c46;
		host_errs = 0;
		dsp_reset = 1'b1;
		i_io_wr = 1'b0;
		i_io_rd = 1'b0;
		i_io_addr = 16'h0000;
		i_io_wdata = 8'h00;
		repeat (10) @(negedge CLK);
		dsp_reset = 1'b0;

		// soft reset handshake
		io_write(`SB_OFS_RESET, 8'h01);
		io_read(`SB_OFS_STATUS, st);
		check_reply("o_io_rdata status in soft reset", {st[7], st}, {1'b0, 8'h7F});
		io_write(`SB_OFS_RESET, 8'h00);
		dsp_read(r);
		check_reply("o_io_rdata reset reply", r, {1'b1, `SB_REPLY_READY});
		io_read(`SB_OFS_STATUS, st);
		check_reply("o_io_rdata status", {st[7], st}, {1'b0, 8'h7F});

		dsp_write(`SB_CMD_VERSION);
		dsp_read(r);
		check_reply("o_io_rdata version major", r, {1'b1, `SB_VER_MAJOR});
		dsp_read(r);
		check_reply("o_io_rdata version minor", r, {1'b1, `SB_VER_MINOR});
		x = rand_byte();
		dsp_write(`SB_CMD_CHECK);
		dsp_write(x);
		dsp_read(r);
		check_reply("o_io_rdata check", r, {1'b1, ~x});
		dsp_write(`SB_CMD_SPK_ON);
		dsp_write(`SB_CMD_SPK_STATUS);
		dsp_read(r);
		check_reply("o_io_rdata speaker on", r, {1'b1, 8'hFF});
		dsp_write(`SB_CMD_SPK_OFF);
		dsp_write(`SB_CMD_SPK_STATUS);
		dsp_read(r);
		check_reply("o_io_rdata speaker off", r, {1'b1, 8'h00});

		// single cycle pcm
		dsp_write(`SB_CMD_SPK_ON);
		dsp_write(`SB_CMD_TIME_CONST);
		dsp_write(8'(TC));
		queue_pcm(PCM_N, 1'b1);
		base = dma_reqs;
		dsp_write(`SB_CMD_PCM_SINGLE);
		dsp_write(8'(PCM_N - 1));
		dsp_write(8'h00);
		wait_irq();
		wait_samples();
		settle();
		check_count("o_dma_req count pcm", dma_reqs - base, PCM_N);
		io_read(`SB_OFS_STATUS, st);
		check_count("o_irq after status read", int'(o_irq), 0);

		// auto-init pcm with the speaker off
		dsp_write(`SB_CMD_SPK_OFF);
		queue_pcm(3 * AUTO_B, 1'b0);
		base = dma_reqs;
		dsp_write(`SB_CMD_BLOCK_SIZE);
		dsp_write(8'(AUTO_B - 1));
		dsp_write(8'h00);
		dsp_write(`SB_CMD_PCM_AUTO);
		wait_irq();
		io_read(`SB_OFS_STATUS, st);
		wait_irq();
		io_read(`SB_OFS_STATUS, st);
		dsp_write(`SB_CMD_EXIT_AUTO); // lands in the third block
		wait_irq();
		io_read(`SB_OFS_STATUS, st);
		wait_samples();
		settle();
		check_count("o_dma_req count auto-init", dma_reqs - base, 3 * AUTO_B);

		// adpcm4 with reference byte
		dsp_write(`SB_CMD_SPK_ON);
		b = rand_byte();
		dma_q.push_back(b);
		exp_q.push_back(pcm_ref(b));
		level = int'(b);
		shift = 0;
		for (int i = 0; i < ADPCM_BYTES - 1; i++)
		begin
			b = rand_byte();
			dma_q.push_back(b);
			for (int n = 0; n < 2; n++)
			begin
				code = (n == 0) ? b[7:4] : b[3:0]; // high code first
				level = adpcm_next(level, shift, code);
				shift = adpcm_shift(shift, code);
				exp_q.push_back(pcm_ref(8'(level)));
			end
		end
		base = dma_reqs;
		dsp_write(`SB_CMD_ADPCM4_REF);
		dsp_write(8'(ADPCM_BYTES - 1));
		dsp_write(8'h00);
		wait_irq();
		io_read(`SB_OFS_STATUS, st);
		wait_samples();
		settle();
		check_count("o_dma_req count adpcm", dma_reqs - base, ADPCM_BYTES);

		// silence block, paused part way
		for (int i = 0; i < SIL_L; i++)
			exp_q.push_back(16'sd0);
		base = strobes;
		dsp_write(`SB_CMD_SILENCE);
		dsp_write(8'(SIL_L - 1));
		dsp_write(8'h00);
		dsp_write(`SB_CMD_PAUSE);
		repeat (4) @(negedge CLK);
		snap = strobes;
		repeat (PAUSE_TICKS * TICK_CYC) @(negedge CLK);
		check_count("o_audio_stb count while paused", strobes, snap);
		dsp_write(`SB_CMD_CONTINUE);
		wait_irq();
		io_read(`SB_OFS_STATUS, st);
		wait_samples();
		settle();
		check_count("o_audio_stb count silence", strobes - base, SIL_L);

		$display("host errors %0d, audio errors %0d, dma errors %0d, samples %0d",
			host_errs, audio_errs, dma_errs, strobes);
		if (host_errs + audio_errs + dma_errs == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* bench/sb_tb_chk.sv */
// dsp top level assertions
// dma pulse width, quiet outputs in reset, read data hold
`timescale 1ns/1ps

module sb_tb_chk
(
	input logic       CLK,
	input logic       dsp_reset,
	input logic       i_io_rd,
	input logic [7:0] i_io_rdata,
	input logic       i_dma_req,
	input logic       i_irq,
	input logic       i_audio_stb
);

	// one pulse per wanted byte
	a_dma_pulse: assert property (@(posedge CLK) disable iff (dsp_reset)
		i_dma_req |=> !i_dma_req)
		else $error("o_dma_req high for two cycles in a row");

	a_reset_quiet: assert property (@(posedge CLK)
		$past(dsp_reset) |-> !i_irq && !i_audio_stb)
		else $error("o_irq or o_audio_stb high during reset");

	// read data only moves on a read strobe
	a_rdata_hold: assert property (@(posedge CLK) disable iff (dsp_reset)
		!$past(i_io_rd) |-> $stable(i_io_rdata))
		else $error("o_io_rdata changed without a read");

endmodule

bind sb_dsp_top sb_tb_chk u_chk
(
	.CLK         (CLK),
	.dsp_reset   (dsp_reset),
	.i_io_rd     (i_io_rd),
	.i_io_rdata  (o_io_rdata),
	.i_dma_req   (o_dma_req),
	.i_irq       (o_irq),
	.i_audio_stb (o_audio_stb)
);

/* rtl/sb_consts.svh */
// sound blaster dsp constants
// port offsets, command codes, reply bytes and sample timer step
`ifndef SB_CONSTS_SVH
`define SB_CONSTS_SVH

`define SB_BASE           16'h0220

// offsets from the base port
`define SB_OFS_RESET      4'h6
`define SB_OFS_READ       4'hA
`define SB_OFS_WRITE      4'hC
`define SB_OFS_STATUS     4'hE

`define SB_CMD_PCM_SINGLE 8'h14
`define SB_CMD_PCM_AUTO   8'h1C
`define SB_CMD_TIME_CONST 8'h40
`define SB_CMD_BLOCK_SIZE 8'h48
`define SB_CMD_ADPCM4     8'h74
`define SB_CMD_ADPCM4_REF 8'h75
`define SB_CMD_ADPCM4_AUTO 8'h7D
`define SB_CMD_SILENCE    8'h80
`define SB_CMD_PAUSE      8'hD0
`define SB_CMD_SPK_ON     8'hD1
`define SB_CMD_SPK_OFF    8'hD3
`define SB_CMD_CONTINUE   8'hD4
`define SB_CMD_SPK_STATUS 8'hD8
`define SB_CMD_EXIT_AUTO  8'hDA
`define SB_CMD_CHECK      8'hE0
`define SB_CMD_VERSION    8'hE1
`define SB_CMD_IRQ        8'hF2

`define SB_REPLY_READY    8'hAA
`define SB_VER_MAJOR      8'h03
`define SB_VER_MINOR      8'h00

`define SB_PRESCALE_W     17
`define SB_TICK_STEP      17'd1966 // one top bit toggle per rate count

`endif

/* rtl/sb_dac_out.sv */
// dsp output stage
// unsigned byte to signed 16-bit, muted by silence or speaker off
`timescale 1ns/1ps

module sb_dac_out
(
	input  logic                CLK,
	input  logic                dsp_reset,
	input  sb_pkg::sample_t     i_sample,
	input  logic                i_spk,
	output logic signed [15:0]  o_audio,
	output logic                o_audio_stb
);

	logic signed [15:0] pcm_s16;

	// flip the offset binary sign, extend, scale by 128
	assign pcm_s16 = {{2{~i_sample.data[7]}}, i_sample.data[6:0], 7'd0};

	always_ff @(posedge CLK)
	begin
		if (dsp_reset)
		begin
			o_audio <= '0;
			o_audio_stb <= 1'b0;
		end
		else
		begin
			o_audio_stb <= i_sample.valid;
			if (!i_spk)
				o_audio <= '0;
			else if (i_sample.valid)
				o_audio <= i_sample.mute ? 16'sd0 : pcm_s16;
		end
	end

endmodule

/* rtl/sb_dsp_cmd.sv */
// dsp command FSM
// dispatches host commands, collects their data bytes and keeps the
// reply byte, speaker state and playback settings
`timescale 1ns/1ps
`include "sb_consts.svh"

module sb_dsp_cmd
(
	input  logic             CLK,
	input  logic             dsp_reset,
	input  logic             i_soft_rst,
	input  sb_pkg::host_wr_t i_host_wr,
	input  logic             i_reply_taken,
	output sb_pkg::reply_t   o_reply,
	output logic             o_busy,
	output logic             o_irq_cmd,
	output logic             o_spk,
	output sb_pkg::pb_ctrl_t o_pb_ctrl
);
	import sb_pkg::*;

	typedef enum logic [2:0] {
		ST_RESET,
		ST_IDLE,
		ST_ARG_LO,
		ST_ARG_HI,
		ST_REPLY,
		ST_VER2
	} state_e;

	state_e     state;
	state_e     reply_next;
	logic       wr_pend;
	logic [7:0] wr_byte;
	logic [7:0] cmd;
	logic [7:0] arg_lo;

	assign o_busy = !(state inside {ST_IDLE, ST_ARG_LO, ST_ARG_HI});

	task automatic start_pb(input pb_mode_e mode, input logic with_ref,
		input logic auto_init, input logic [15:0] len);
		o_pb_ctrl.start <= 1'b1;
		o_pb_ctrl.mode <= mode;
		o_pb_ctrl.refbyte <= with_ref;
		o_pb_ctrl.autoinit <= auto_init;
		o_pb_ctrl.pause <= 1'b0;
		o_pb_ctrl.length <= len;
	endtask

	task automatic load_reply(input logic [7:0] data, input state_e next);
		o_reply.ready <= 1'b1;
		o_reply.data <= data;
		reply_next <= next;
		state <= ST_REPLY;
	endtask

	always_ff @(posedge CLK)
	begin
		if (dsp_reset)
		begin
			state <= ST_RESET;
			reply_next <= ST_IDLE;
			wr_pend <= 1'b0;
			o_reply <= '0;
			o_irq_cmd <= 1'b0;
			o_spk <= 1'b0;
			o_pb_ctrl <= '0;
		end
		else
		begin
			o_irq_cmd <= 1'b0;
			o_pb_ctrl.start <= 1'b0;
			if (i_reply_taken)
				o_reply.ready <= 1'b0;

			if (i_soft_rst)
			begin
				state <= ST_RESET; // held here, speaker survives
				wr_pend <= 1'b0;
				o_reply.ready <= 1'b0;
				o_pb_ctrl <= '0;
			end
			else
			begin
				case (state)
					ST_RESET: load_reply(`SB_REPLY_READY, ST_IDLE);
					ST_IDLE:
					begin
						if (wr_pend)
						begin
							wr_pend <= 1'b0;
							cmd <= wr_byte;
							case (wr_byte)
								`SB_CMD_PCM_SINGLE, `SB_CMD_TIME_CONST, `SB_CMD_BLOCK_SIZE,
								`SB_CMD_ADPCM4, `SB_CMD_ADPCM4_REF, `SB_CMD_SILENCE,
								`SB_CMD_CHECK:
									state <= ST_ARG_LO;
								`SB_CMD_PCM_AUTO:
									start_pb(PB_PCM, 1'b0, 1'b1, o_pb_ctrl.blksize);
								`SB_CMD_ADPCM4_AUTO:
									start_pb(PB_ADPCM4, 1'b1, 1'b1, o_pb_ctrl.blksize);
								`SB_CMD_PAUSE:      o_pb_ctrl.pause <= 1'b1;
								`SB_CMD_CONTINUE:   o_pb_ctrl.pause <= 1'b0;
								`SB_CMD_SPK_ON:     o_spk <= 1'b1;
								`SB_CMD_SPK_OFF:    o_spk <= 1'b0;
								`SB_CMD_SPK_STATUS: load_reply({8{o_spk}}, ST_IDLE);
								`SB_CMD_EXIT_AUTO:  o_pb_ctrl.autoinit <= 1'b0; // ends after this block
								`SB_CMD_VERSION:    load_reply(`SB_VER_MAJOR, ST_VER2);
								`SB_CMD_IRQ:        o_irq_cmd <= 1'b1;
								default: ;
							endcase
						end
					end
					ST_ARG_LO:
					begin
						if (wr_pend)
						begin
							wr_pend <= 1'b0;
							arg_lo <= wr_byte;
							case (cmd)
								`SB_CMD_TIME_CONST:
								begin
									o_pb_ctrl.tc <= wr_byte;
									state <= ST_IDLE;
								end
								`SB_CMD_CHECK: load_reply(~wr_byte, ST_IDLE);
								default:       state <= ST_ARG_HI;
							endcase
						end
					end
					ST_ARG_HI:
					begin
						if (wr_pend)
						begin
							wr_pend <= 1'b0;
							state <= ST_IDLE;
							case (cmd)
								`SB_CMD_PCM_SINGLE:
									start_pb(PB_PCM, 1'b0, 1'b0, {wr_byte, arg_lo});
								`SB_CMD_ADPCM4:
									start_pb(PB_ADPCM4, 1'b0, 1'b0, {wr_byte, arg_lo});
								`SB_CMD_ADPCM4_REF:
									start_pb(PB_ADPCM4, 1'b1, 1'b0, {wr_byte, arg_lo});
								`SB_CMD_SILENCE:
									start_pb(PB_SILENCE, 1'b0, 1'b0, {wr_byte, arg_lo});
								`SB_CMD_BLOCK_SIZE: o_pb_ctrl.blksize <= {wr_byte, arg_lo};
								default: ;
							endcase
						end
					end
					ST_REPLY:
					begin
						if (i_reply_taken)
							state <= reply_next;
					end
					ST_VER2: load_reply(`SB_VER_MINOR, ST_IDLE);
					default: state <= ST_IDLE;
				endcase
			end

			if (i_host_wr.valid & !i_soft_rst)
				wr_pend <= 1'b1;
		end
		if (i_host_wr.valid)
			wr_byte <= i_host_wr.data;
	end

endmodule

/* rtl/sb_dsp_top.sv */
// sound blaster dsp
// host port, command FSM, playback engine and output stage
`timescale 1ns/1ps

module sb_dsp_top
(
	input  logic               CLK,
	input  logic               dsp_reset,
	input  logic               i_io_wr,
	input  logic               i_io_rd,
	input  logic [15:0]        i_io_addr,
	input  logic [7:0]         i_io_wdata,
	output logic [7:0]         o_io_rdata,
	output logic               o_dma_req,
	input  logic               i_dma_valid,
	input  logic [7:0]         i_dma_data,
	output logic               o_irq,
	output logic signed [15:0] o_audio,
	output logic               o_audio_stb
);
	import sb_pkg::*;

	host_wr_t host_wr;
	reply_t   reply;
	pb_ctrl_t pb_ctrl;
	sample_t  sample;
	logic     reply_taken;
	logic     soft_rst;
	logic     busy;
	logic     irq_cmd;
	logic     spk;
	logic     block_end;

	sb_host_port u_host_port
	(
		.CLK           (CLK),
		.dsp_reset     (dsp_reset),
		.i_io_wr       (i_io_wr),
		.i_io_rd       (i_io_rd),
		.i_io_addr     (i_io_addr),
		.i_io_wdata    (i_io_wdata),
		.i_reply       (reply),
		.i_busy        (busy),
		.i_irq_cmd     (irq_cmd),
		.i_block_end   (block_end),
		.o_io_rdata    (o_io_rdata),
		.o_host_wr     (host_wr),
		.o_reply_taken (reply_taken),
		.o_soft_rst    (soft_rst),
		.o_irq         (o_irq)
	);

	sb_dsp_cmd u_dsp_cmd
	(
		.CLK           (CLK),
		.dsp_reset     (dsp_reset),
		.i_soft_rst    (soft_rst),
		.i_host_wr     (host_wr),
		.i_reply_taken (reply_taken),
		.o_reply       (reply),
		.o_busy        (busy),
		.o_irq_cmd     (irq_cmd),
		.o_spk         (spk),
		.o_pb_ctrl     (pb_ctrl)
	);

	sb_playback u_playback
	(
		.CLK         (CLK),
		.dsp_reset   (dsp_reset),
		.i_soft_rst  (soft_rst),
		.i_ctrl      (pb_ctrl),
		.i_dma_valid (i_dma_valid),
		.i_dma_data  (i_dma_data),
		.o_dma_req   (o_dma_req),
		.o_block_end (block_end),
		.o_sample    (sample)
	);

	sb_dac_out u_dac_out
	(
		.CLK         (CLK),
		.dsp_reset   (dsp_reset),
		.i_sample    (sample),
		.i_spk       (spk),
		.o_audio     (o_audio),
		.o_audio_stb (o_audio_stb)
	);

endmodule

/* rtl/sb_host_port.sv */
// dsp host port
// decodes i/o reads and writes at the base port, holds the soft reset
// and interrupt flag, and registers read data
`timescale 1ns/1ps
`include "sb_consts.svh"

module sb_host_port
(
	input  logic             CLK,
	input  logic             dsp_reset,
	input  logic             i_io_wr,
	input  logic             i_io_rd,
	input  logic [15:0]      i_io_addr,
	input  logic [7:0]       i_io_wdata,
	input  sb_pkg::reply_t   i_reply,
	input  logic             i_busy,
	input  logic             i_irq_cmd,
	input  logic             i_block_end,
	output logic [7:0]       o_io_rdata,
	output sb_pkg::host_wr_t o_host_wr,
	output logic             o_reply_taken,
	output logic             o_soft_rst,
	output logic             o_irq
);

	localparam logic [15:0] sb_base = `SB_BASE;

	logic       hit;
	logic [3:0] ofs;
	logic       wr_hit;
	logic       rd_hit;

	assign hit    = i_io_addr[15:4] == sb_base[15:4];
	assign ofs    = i_io_addr[3:0];
	assign wr_hit = i_io_wr & hit;
	assign rd_hit = i_io_rd & hit;

	always_ff @(posedge CLK)
	begin
		if (dsp_reset)
		begin
			o_host_wr.valid <= 1'b0;
			o_reply_taken <= 1'b0;
			o_soft_rst <= 1'b0;
			o_irq <= 1'b0;
			o_io_rdata <= 8'hFF;
		end
		else
		begin
			o_host_wr.valid <= wr_hit & (ofs == `SB_OFS_WRITE);
			o_reply_taken <= rd_hit & (ofs == `SB_OFS_READ);

			if (wr_hit & (ofs == `SB_OFS_RESET))
				o_soft_rst <= i_io_wdata[0];

			// a new request wins over the acknowledge
			if (i_irq_cmd | i_block_end)
				o_irq <= 1'b1;
			else if (rd_hit & (ofs == `SB_OFS_STATUS))
				o_irq <= 1'b0;

			if (i_io_rd)
			begin
				if (!hit)
					o_io_rdata <= 8'hFF;
				else
				begin
					case (ofs)
						`SB_OFS_READ:   o_io_rdata <= i_reply.data;
						`SB_OFS_STATUS: o_io_rdata <= {i_reply.ready, 7'h7F};
						`SB_OFS_WRITE:  o_io_rdata <= {i_busy, 7'h7F};
						default:        o_io_rdata <= 8'hFF;
					endcase
				end
			end
		end
		o_host_wr.data <= i_io_wdata;
	end

endmodule

/* rtl/sb_pkg.sv */
// sound blaster dsp types
// shared between the host port, command FSM, playback and output stage
package sb_pkg;

	// data byte written by the host to the dsp
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} host_wr_t;

	// byte waiting for the host at the read port
	typedef struct packed {
		logic       ready;
		logic [7:0] data;
	} reply_t;

	typedef enum logic [1:0] {
		PB_OFF,
		PB_PCM,
		PB_ADPCM4,
		PB_SILENCE
	} pb_mode_e;

	typedef struct packed {
		logic        start;    // one cycle, loads a new block
		pb_mode_e    mode;
		logic        refbyte;  // first dma byte is the adpcm reference
		logic        autoinit;
		logic        pause;
		logic [15:0] length;
		logic [15:0] blksize;
		logic [7:0]  tc;
	} pb_ctrl_t;

	typedef struct packed {
		logic       sign;
		logic [2:0] mag;
	} adpcm_code_t;

	// a dma byte is either one pcm sample or two adpcm codes
	typedef union packed {
		logic [7:0] pcm;
		struct packed {
			adpcm_code_t hi; // played first
			adpcm_code_t lo;
		} adpcm;
	} dma_byte_u;

	typedef struct packed {
		logic       valid;
		logic       mute;
		logic [7:0] data; // unsigned, 80 is midscale
	} sample_t;

endpackage

/* rtl/sb_playback.sv */
// dsp playback engine
// sample rate timer, block length counting, dma byte requests and
// 4-bit adpcm decoding
`timescale 1ns/1ps
`include "sb_consts.svh"

module sb_playback
(
	input  logic              CLK,
	input  logic              dsp_reset,
	input  logic              i_soft_rst,
	input  sb_pkg::pb_ctrl_t  i_ctrl,
	input  logic              i_dma_valid,
	input  sb_pkg::dma_byte_u i_dma_data,
	output logic              o_dma_req,
	output logic              o_block_end,
	output sb_pkg::sample_t   o_sample
);
	import sb_pkg::*;

	logic [`SB_PRESCALE_W-1:0] prescale;
	logic                      pre_top_q;
	logic [7:0]                rate_cnt;
	logic                      pre_edge;
	logic                      tick;

	pb_mode_e    mode;
	logic [15:0] len;
	logic        last;      // byte in flight or held ends the block
	logic        ref_pend;
	logic        req_out;
	logic        direct;    // requested byte goes straight out
	logic        have_byte;
	logic        nib_lo;
	dma_byte_u   cur_byte;
	logic [7:0]  adpcm_ref;
	logic [1:0]  shift;

	adpcm_code_t code;
	logic [7:0]  step;
	logic [8:0]  sum;
	logic [7:0]  clip;

	assign pre_edge = pre_top_q != prescale[`SB_PRESCALE_W-1];
	assign tick = pre_edge & (rate_cnt == 8'hFF);

	always_ff @(posedge CLK)
	begin
		if (dsp_reset)
		begin
			prescale <= '0;
			pre_top_q <= 1'b0;
			rate_cnt <= 8'h00;
		end
		else
		begin
			prescale <= prescale + `SB_TICK_STEP;
			pre_top_q <= prescale[`SB_PRESCALE_W-1];
			if (tick)
				rate_cnt <= i_ctrl.tc;
			else if (pre_edge)
				rate_cnt <= rate_cnt + 8'd1;
		end
	end

	always_comb
	begin
		code = nib_lo ? cur_byte.adpcm.lo : cur_byte.adpcm.hi;
		step = ({5'd0, code.mag} << shift) + ((shift != 2'd0) ? (8'd1 << (shift - 2'd1)) : 8'd0);
		if (code.sign)
			sum = {1'b0, adpcm_ref} - {1'b0, step};
		else
			sum = {1'b0, adpcm_ref} + {1'b0, step};
		if (sum[8])
			clip = code.sign ? 8'h00 : 8'hFF; // borrow or carry
		else
			clip = sum[7:0];
	end

	always_ff @(posedge CLK)
	begin
		if (dsp_reset | i_soft_rst)
		begin
			mode <= PB_OFF;
			len <= 16'd0;
			last <= 1'b0;
			ref_pend <= 1'b0;
			req_out <= 1'b0;
			direct <= 1'b0;
			have_byte <= 1'b0;
			nib_lo <= 1'b0;
			adpcm_ref <= 8'h80;
			shift <= 2'd0;
			o_dma_req <= 1'b0;
			o_block_end <= 1'b0;
			o_sample.valid <= 1'b0;
		end
		else
		begin
			o_dma_req <= 1'b0;
			o_block_end <= 1'b0;
			o_sample.valid <= 1'b0;

			if (i_dma_valid)
			begin
				req_out <= 1'b0;
				if (direct)
				begin
					o_sample.valid <= 1'b1;
					o_sample.mute <= 1'b0;
					o_sample.data <= i_dma_data.pcm;
					if (ref_pend)
					begin
						adpcm_ref <= i_dma_data.pcm;
						ref_pend <= 1'b0;
					end
				end
				else
				begin
					cur_byte <= i_dma_data;
					have_byte <= 1'b1;
				end
			end

			if (i_ctrl.start)
			begin
				mode <= i_ctrl.mode;
				len <= i_ctrl.length;
				last <= 1'b0;
				ref_pend <= i_ctrl.refbyte;
				req_out <= 1'b0;
				have_byte <= 1'b0;
				nib_lo <= 1'b0;
				adpcm_ref <= 8'h80;
				shift <= 2'd0;
			end
			else if (tick & !i_ctrl.pause)
			begin
				case (mode)
					PB_PCM, PB_SILENCE:
					begin
						if (mode == PB_PCM)
						begin
							o_dma_req <= 1'b1;
							req_out <= 1'b1;
							direct <= 1'b1;
						end
						else
						begin
							o_sample.valid <= 1'b1;
							o_sample.mute <= 1'b1;
							o_sample.data <= 8'h80;
						end
						if (len != 16'd0)
							len <= len - 16'd1;
						else
						begin
							o_block_end <= 1'b1;
							if (i_ctrl.autoinit)
								len <= i_ctrl.blksize;
							else
								mode <= PB_OFF;
						end
					end
					PB_ADPCM4:
					begin
						if (!req_out & (ref_pend | !have_byte))
						begin
							o_dma_req <= 1'b1;
							req_out <= 1'b1;
							direct <= ref_pend;
							last <= len == 16'd0;
							len <= len - 16'd1;
						end
						else if (!req_out)
						begin
							o_sample.valid <= 1'b1;
							o_sample.mute <= 1'b0;
							o_sample.data <= clip;
							adpcm_ref <= clip;
							if ((code.mag >= 3'd5) & (shift != 2'd3))
								shift <= shift + 2'd1;
							else if ((code.mag == 3'd0) & (shift != 2'd0))
								shift <= shift - 2'd1;
							nib_lo <= !nib_lo;
							if (nib_lo)
							begin
								have_byte <= 1'b0;
								if (last & !i_ctrl.autoinit)
									mode <= PB_OFF;
								else
								begin
									// next byte right after the low code
									o_dma_req <= 1'b1;
									req_out <= 1'b1;
									direct <= 1'b0;
									last <= (last ? i_ctrl.blksize : len) == 16'd0;
									len <= (last ? i_ctrl.blksize : len) - 16'd1;
								end
								o_block_end <= last;
							end
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

/* tb.f */
+incdir+rtl
rtl/sb_pkg.sv
rtl/sb_host_port.sv
rtl/sb_dsp_cmd.sv
rtl/sb_playback.sv
rtl/sb_dac_out.sv
rtl/sb_dsp_top.sv
bench/sb_tb_chk.sv
bench/sb_tb.sv
